// File: rtl/maze_pkg.sv
/*
 * Maze view shared definitions
 * Map, minimap and view geometry, colours, request and shape encodings
 */
package maze_pkg;

    // ==============================
    // Map and pose types
    // ==============================
    localparam int MAP_COLS = 11;
    localparam int MAP_ROWS = 21;

    typedef logic [3:0] col_t;    // Map column
    typedef logic [4:0] row_t;    // Map row
    typedef logic [3:0] depth_t;  // Empty cells ahead

    // North decreases the row number
    typedef enum logic [1:0] {
        EAST  = 2'd0,
        NORTH = 2'd1,
        WEST  = 2'd2,
        SOUTH = 2'd3
    } dir_t;

    typedef enum logic [1:0] {
        SHP_RECT,
        SHP_TRI,
        SHP_QUAD
    } shape_t;

    typedef enum logic [2:0] {
        REQ_CLEAR,
        REQ_CELL,
        REQ_PLAYER,
        REQ_FRAME,
        REQ_FRONT
    } req_kind_t;

    // ==============================
    // Screen geometry
    // ==============================
    localparam logic [12:0] BLOCK      = 13'd20;   // Minimap cell size
    localparam logic [12:0] HALF_BLOCK = 13'd10;
    localparam logic [12:0] MAP_X0     = 13'd420;  // Minimap offset
    localparam logic [12:0] MAP_Y0     = 13'd30;
    localparam logic [12:0] VIEW_W     = 13'd400;  // First-person view
    localparam logic [12:0] VIEW_H     = 13'd400;
    localparam logic [12:0] SCREEN_W   = 13'd640;
    localparam logic [12:0] SCREEN_H   = 13'd480;

    localparam depth_t MAX_DEPTH = 4'd10;

    localparam logic [8:0] COL_FLOOR = 9'b000011011;
    localparam logic [8:0] COL_WALL  = 9'b000001001;
    localparam logic [8:0] COL_LINE  = 9'b111111111;

    // Bit set means wall, column 0 is the leftmost bit
    localparam logic [0:MAP_COLS-1] maze_map [0:MAP_ROWS-1] = '{
        11'b11111111111,
        11'b10001000001,
        11'b11101110101,
        11'b10100010101,
        11'b10111011101,
        11'b10001000001,
        11'b10111101101,
        11'b10000000101,
        11'b10111011101,
        11'b10100010001,
        11'b10101000111,
        11'b10001010001,
        11'b10101111101,
        11'b10100010001,
        11'b10111010111,
        11'b10001000101,
        11'b11101111101,
        11'b10001000101,
        11'b10111010101,
        11'b10000010001,
        11'b11111111111
    };

    // Perspective inset of the front wall per depth
    localparam logic [12:0] depth_dist [0:10] = '{
        13'd30,  13'd55,  13'd78,  13'd94,  13'd110, 13'd124,
        13'd134, 13'd143, 13'd151, 13'd158, 13'd164
    };

endpackage

// File: rtl/shape_req_if.sv
`timescale 1ns/1ps
/*
 * Shape request bus from the frame sequencer to the geometry unit
 * req is a single-cycle strobe, fields valid in that cycle
 */
interface shape_req_if import maze_pkg::*; ();

    req_kind_t kind;   // Which shape of the frame
    col_t      col;    // Cell or player column
    row_t      row;    // Cell or player row
    dir_t      dir;    // Player facing
    depth_t    depth;  // Front wall depth
    logic      req;

    modport issue (
        output kind, col, row, dir, depth, req
    );

    modport accept (
        input kind, col, row, dir, depth, req
    );

endinterface

// File: rtl/pose_regs.sv
`timescale 1ns/1ps
/*
 * Player pose registers
 * Captures column, row and facing, and the unit step straight ahead
 */
module pose_regs import maze_pkg::*; (
    input  logic              clk,
    input  logic              rstn,
    input  logic              load_pose,
    input  col_t              pose_col_in,
    input  row_t              pose_row_in,
    input  dir_t              pose_dir_in,
    output col_t              col,
    output row_t              row,
    output dir_t              dir,
    output logic signed [1:0] step_col,
    output logic signed [1:0] step_row
);

    always_ff @(posedge clk) begin
        if (!rstn) begin
            col      <= 4'd1;     // Start cell of the maze
            row      <= 5'd7;
            dir      <= SOUTH;
            step_col <= 2'sd0;
            step_row <= 2'sd1;
        end else if (load_pose) begin
            col <= pose_col_in;
            row <= pose_row_in;
            dir <= pose_dir_in;
            case (pose_dir_in)
                EAST:    begin step_col <= 2'sd1;  step_row <= 2'sd0;  end
                NORTH:   begin step_col <= 2'sd0;  step_row <= -2'sd1; end
                WEST:    begin step_col <= -2'sd1; step_row <= 2'sd0;  end
                default: begin step_col <= 2'sd0;  step_row <= 2'sd1;  end  // South
            endcase
        end
    end

endmodule

// File: rtl/depth_probe.sv
`timescale 1ns/1ps
/*
 * Forward depth probe
 * Walks the map one cell per cycle ahead of the player and counts
 * the empty cells up to the first wall, capped at MAX_DEPTH
 */
module depth_probe import maze_pkg::*; (
    input  logic              clk,
    input  logic              rstn,
    input  logic              start,
    input  col_t              col,
    input  row_t              row,
    input  logic signed [1:0] step_col,
    input  logic signed [1:0] step_row,
    output depth_t            depth,
    output logic              depth_valid
);

    col_t   probe_col;   // Cell under test
    row_t   probe_row;
    depth_t count;       // Empty cells passed so far
    logic   running;
    logic   cell_wall;

    // Anything off the map counts as wall
    assign cell_wall = (probe_col < col_t'(MAP_COLS) && probe_row < row_t'(MAP_ROWS))
                     ? maze_map[probe_row][probe_col] : 1'b1;

    // ==============================
    // Probe walk
    // ==============================
    always_ff @(posedge clk) begin
        if (!rstn) begin
            running     <= 1'b0;
            depth_valid <= 1'b0;
        end else begin
            depth_valid <= 1'b0;
            if (start) begin
                // First cell strictly ahead
                probe_col <= col + col_t'(step_col);
                probe_row <= row + row_t'(step_row);
                count     <= '0;
                running   <= 1'b1;
            end else if (running) begin
                if (cell_wall || count == MAX_DEPTH) begin
                    depth       <= count;
                    depth_valid <= 1'b1;
                    running     <= 1'b0;
                end else begin
                    count     <= count + 1'b1;
                    probe_col <= probe_col + col_t'(step_col);
                    probe_row <= probe_row + row_t'(step_row);
                end
            end
        end
    end

endmodule

// File: rtl/frame_sequencer.sv
`timescale 1ns/1ps
/*
 * Frame sequencer
 * Orders clear, minimap cells, player, frame and front wall requests,
 * one at a time, each held until the rasteriser reports done
 */
module frame_sequencer import maze_pkg::*; (
    input  logic       clk,
    input  logic       rstn,
    input  logic       refresh,
    input  logic       cmd_done,
    input  logic       depth_valid,
    input  depth_t     depth,
    input  col_t       col,          // Loaded player pose
    input  row_t       row,
    input  dir_t       dir,
    output logic       load_pose,
    output logic       probe_start,
    shape_req_if.issue req,
    output logic       busy,
    output logic       done
);

    typedef enum logic [3:0] {
        IDLE, LOAD, CLEAR, CELL, PLAYER, WAIT_DEPTH, FRAME, FRONT, FINISH
    } state_t;

    state_t state;
    col_t   cell_col;    // Minimap walk
    row_t   cell_row;
    depth_t depth_q;     // Probe result of this frame
    logic   depth_got;

    always_ff @(posedge clk) begin
        if (!rstn) begin
            state       <= IDLE;
            busy        <= 1'b0;
            done        <= 1'b0;
            load_pose   <= 1'b0;
            probe_start <= 1'b0;
            req.req     <= 1'b0;
            depth_got   <= 1'b0;
            cell_col    <= '0;
            cell_row    <= '0;
        end else begin
            // Strobes default low
            req.req     <= 1'b0;
            load_pose   <= 1'b0;
            probe_start <= 1'b0;
            done        <= 1'b0;

            if (depth_valid) begin
                depth_q   <= depth;
                depth_got <= 1'b1;
            end

            case (state)
                IDLE, FINISH: begin
                    state <= IDLE;
                    if (refresh) begin
                        state     <= LOAD;
                        busy      <= 1'b1;
                        load_pose <= 1'b1;
                        req.req   <= 1'b1;    // Clear goes out with the pose load
                        req.kind  <= REQ_CLEAR;
                    end
                end
                LOAD: begin
                    depth_got <= 1'b0;
                    state     <= CLEAR;
                end
                CLEAR: if (cmd_done) begin
                    cell_col <= '0;
                    cell_row <= '0;
                    req.col  <= '0;
                    req.row  <= '0;
                    req.kind <= REQ_CELL;
                    req.req  <= 1'b1;
                    state    <= CELL;
                end
                CELL: if (cmd_done) begin
                    req.req <= 1'b1;
                    if (cell_col != col_t'(MAP_COLS - 1)) begin
                        cell_col <= cell_col + 1'b1;
                        req.col  <= cell_col + 1'b1;
                        req.row  <= cell_row;
                        req.kind <= REQ_CELL;
                    end else if (cell_row != row_t'(MAP_ROWS - 1)) begin
                        cell_col <= '0;
                        cell_row <= cell_row + 1'b1;
                        req.col  <= '0;
                        req.row  <= cell_row + 1'b1;
                        req.kind <= REQ_CELL;
                    end else begin
                        // Last cell done, probe runs behind the triangle
                        req.col     <= col;
                        req.row     <= row;
                        req.dir     <= dir;
                        req.kind    <= REQ_PLAYER;
                        probe_start <= 1'b1;
                        state       <= PLAYER;
                    end
                end
                PLAYER: if (cmd_done) begin
                    req.kind <= REQ_FRAME;
                    req.req  <= 1'b1;
                    state    <= FRAME;
                end
                FRAME: if (cmd_done) begin
                    if (depth_got || depth_valid) begin
                        req.depth <= depth_valid ? depth : depth_q;
                        req.kind  <= REQ_FRONT;
                        req.req   <= 1'b1;
                        state     <= FRONT;
                    end else begin
                        state <= WAIT_DEPTH;
                    end
                end
                WAIT_DEPTH: if (depth_valid) begin
                    req.depth <= depth;
                    req.kind  <= REQ_FRONT;
                    req.req   <= 1'b1;
                    state     <= FRONT;
                end
                FRONT: if (cmd_done) begin
                    busy  <= 1'b0;
                    done  <= 1'b1;
                    state <= FINISH;
                end
                default: state <= IDLE;
            endcase
        end
    end

endmodule

// File: rtl/shape_geometry.sv
`timescale 1ns/1ps
/*
 * Shape geometry
 * Turns a shape request into a registered rasteriser command
 */
module shape_geometry import maze_pkg::*; #(
    parameter int CORDW = 16    // Signed coordinate width
) (
    input  logic                    clk,
    input  logic                    rstn,
    shape_req_if.accept             req,
    output logic                    cmd_start,
    output shape_t                  cmd_shape,
    output logic [8:0]              cmd_color,
    output logic signed [CORDW-1:0] cmd_x0, cmd_y0,
    output logic signed [CORDW-1:0] cmd_x1, cmd_y1,
    output logic signed [CORDW-1:0] cmd_x2, cmd_y2,
    output logic signed [CORDW-1:0] cmd_x3, cmd_y3
);

    typedef logic signed [CORDW-1:0] coord_t;

    localparam coord_t BLK  = coord_t'(BLOCK);
    localparam coord_t HBLK = coord_t'(HALF_BLOCK);
    localparam coord_t VW   = coord_t'(VIEW_W);
    localparam coord_t VH   = coord_t'(VIEW_H);

    coord_t   bx, by;           // Top-left of the addressed cell
    coord_t   d;                // Front wall inset
    coord_t   nx [0:3];
    coord_t   ny [0:3];
    shape_t   nxt_shape;
    logic [8:0] nxt_color;

    always_comb begin
        bx = coord_t'(MAP_X0) + coord_t'(req.col) * BLK;
        by = coord_t'(MAP_Y0) + coord_t'(req.row) * BLK;
        d  = coord_t'(depth_dist[req.depth]);
        nxt_shape = SHP_RECT;
        nxt_color = COL_FLOOR;
        for (int i = 0; i < 4; i++) begin
            nx[i] = '0;   // Unused vertices read as zero
            ny[i] = '0;
        end
        case (req.kind)
            REQ_CLEAR: begin
                nx[1] = coord_t'(SCREEN_W);
                ny[1] = coord_t'(SCREEN_H);
            end
            REQ_CELL: begin
                nxt_color = maze_map[req.row][req.col] ? COL_WALL : COL_FLOOR;
                nx[0] = bx;        ny[0] = by;
                nx[1] = bx + BLK;  ny[1] = by + BLK;
            end
            REQ_PLAYER: begin
                nxt_shape = SHP_TRI;
                nxt_color = COL_WALL;
                case (req.dir)   // Apex points the way the player faces
                    EAST: begin
                        nx[0] = bx;         ny[0] = by;
                        nx[1] = bx + BLK;   ny[1] = by + HBLK;
                        nx[2] = bx;         ny[2] = by + BLK;
                    end
                    NORTH: begin
                        nx[0] = bx + HBLK;  ny[0] = by;
                        nx[1] = bx + BLK;   ny[1] = by + BLK;
                        nx[2] = bx;         ny[2] = by + BLK;
                    end
                    WEST: begin
                        nx[0] = bx + BLK;   ny[0] = by;
                        nx[1] = bx + BLK;   ny[1] = by + BLK;
                        nx[2] = bx;         ny[2] = by + HBLK;
                    end
                    default: begin
                        nx[0] = bx;         ny[0] = by;
                        nx[1] = bx + BLK;   ny[1] = by;
                        nx[2] = bx + HBLK;  ny[2] = by + BLK;
                    end
                endcase
            end
            REQ_FRAME: begin
                nxt_shape = SHP_QUAD;
                nxt_color = COL_LINE;
                nx[1] = VW;  nx[2] = VW;
                ny[2] = VH;  ny[3] = VH;
            end
            REQ_FRONT: begin
                nxt_shape = SHP_QUAD;
                nxt_color = COL_LINE;
                nx[0] = d;       ny[0] = d;
                nx[1] = VW - d;  ny[1] = d;
                nx[2] = VW - d;  ny[2] = VH - d;
                nx[3] = d;       ny[3] = VH - d;
            end
            default: ;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rstn) cmd_start <= 1'b0;
        else       cmd_start <= req.req;
    end

    // Command held until the next request
    always_ff @(posedge clk) begin
        if (req.req) begin
            cmd_shape <= nxt_shape;
            cmd_color <= nxt_color;
            cmd_x0 <= nx[0];  cmd_y0 <= ny[0];
            cmd_x1 <= nx[1];  cmd_y1 <= ny[1];
            cmd_x2 <= nx[2];  cmd_y2 <= ny[2];
            cmd_x3 <= nx[3];  cmd_y3 <= ny[3];
        end
    end

endmodule

// File: rtl/maze_top.sv
`timescale 1ns/1ps
/*
 * Maze view command generator, top level
 * Pose in, one shape command at a time out to an external rasteriser
 */
module maze_top import maze_pkg::*; #(
    parameter int CORDW = 16
) (
    input  logic                    clk,
    input  logic                    rstn,
    input  logic                    refresh,
    input  col_t                    pose_col,
    input  row_t                    pose_row,
    input  dir_t                    pose_dir,
    input  logic                    cmd_done,
    output logic                    cmd_start,
    output shape_t                  cmd_shape,
    output logic [8:0]              cmd_color,
    output logic signed [CORDW-1:0] cmd_x0, cmd_y0,
    output logic signed [CORDW-1:0] cmd_x1, cmd_y1,
    output logic signed [CORDW-1:0] cmd_x2, cmd_y2,
    output logic signed [CORDW-1:0] cmd_x3, cmd_y3,
    output logic                    busy,
    output logic                    done
);

    logic              load_pose, probe_start, depth_valid;
    col_t              cur_col;
    row_t              cur_row;
    dir_t              cur_dir;
    logic signed [1:0] step_col, step_row;
    depth_t            depth;

    shape_req_if req_bus ();

    pose_regs i_pose_regs (
        .clk, .rstn, .load_pose,
        .pose_col_in (pose_col), .pose_row_in (pose_row), .pose_dir_in (pose_dir),
        .col (cur_col), .row (cur_row), .dir (cur_dir),
        .step_col, .step_row
    );

    depth_probe i_depth_probe (
        .clk, .rstn, .start (probe_start),
        .col (cur_col), .row (cur_row), .step_col, .step_row,
        .depth, .depth_valid
    );

    frame_sequencer i_frame_sequencer (
        .clk, .rstn, .refresh, .cmd_done, .depth_valid, .depth,
        .col (cur_col), .row (cur_row), .dir (cur_dir),
        .load_pose, .probe_start, .req (req_bus.issue), .busy, .done
    );

    shape_geometry #(.CORDW(CORDW)) i_shape_geometry (
        .clk, .rstn, .req (req_bus.accept),
        .cmd_start, .cmd_shape, .cmd_color,
        .cmd_x0, .cmd_y0, .cmd_x1, .cmd_y1,
        .cmd_x2, .cmd_y2, .cmd_x3, .cmd_y3
    );

endmodule

// File: tb/maze_checker.sv
`timescale 1ns/1ps
/*
 * Rasteriser command protocol assertions, bound into maze_top
 */
module maze_checker #(
    parameter int CORDW = 16
) (
    input logic               clk,
    input logic               rstn,
    input logic               cmd_start,
    input logic               cmd_done,
    input logic               busy,
    input logic               done,
    input logic [1:0]         cmd_shape,
    input logic [8:0]         cmd_color,
    input logic [8*CORDW-1:0] cmd_vtx     // All eight coordinates
);

    logic outstanding;   // Command issued, done not seen yet

    always_ff @(posedge clk) begin
        if (!rstn) begin
            outstanding <= 1'b0;
        end else if (cmd_start) begin
            outstanding <= 1'b1;
        end else if (cmd_done) begin
            outstanding <= 1'b0;
        end
    end

    // ==============================
    // Protocol properties
    // ==============================
    a_start_pulse: assert property (@(posedge clk) disable iff (!rstn)
        cmd_start |=> !cmd_start)
        else $error("cmd_start held longer than one cycle");

    a_fields_stable: assert property (@(posedge clk) disable iff (!rstn)
        outstanding |-> $stable({cmd_shape, cmd_color, cmd_vtx}))
        else $error("command fields changed before cmd_done");

    a_start_busy: assert property (@(posedge clk) disable iff (!rstn)
        cmd_start |-> busy)
        else $error("cmd_start seen while not busy");

    a_done_idle: assert property (@(posedge clk) disable iff (!rstn)
        done |=> !busy)
        else $error("busy still high after done");

endmodule

bind maze_top maze_checker #(.CORDW(CORDW)) i_maze_checker (
    .clk, .rstn, .cmd_start, .cmd_done, .busy, .done, .cmd_shape, .cmd_color,
    .cmd_vtx ({cmd_x0, cmd_y0, cmd_x1, cmd_y1, cmd_x2, cmd_y2, cmd_x3, cmd_y3})
);

// File: tb/maze_tb.sv
`timescale 1ns/1ps
/*
 * Maze view testbench
 * Plays the rasteriser with random done delays and checks each frame's
 * commands against the minimap, player and view rules
 */
module maze_tb import maze_pkg::*; ;

    localparam int CORDW    = 16;
    localparam int NUM_CMDS = 235;   // Clear, 231 cells, player, frame, front

    typedef struct packed {
        int shape;
        int color;
        int x0, y0, x1, y1, x2, y2, x3, y3;
    } cmd_t;

    typedef struct packed {
        logic [95:0] name;    // Up to 12 characters
        int          col;
        int          row;
        dir_t        dir;
        int          depth;   // Expected empty cells ahead
        logic        poke;    // Extra refresh mid-frame
    } stim_t;

    stim_t stim_table [0:5] = '{
        '{"south_start",  1, 7,  SOUTH, 8,  1'b0},
        '{"east_refresh", 1, 7,  EAST,  6,  1'b1},
        '{"west_wall",    1, 7,  WEST,  0,  1'b0},
        '{"north_run",    1, 7,  NORTH, 4,  1'b0},
        '{"long_south",   1, 3,  SOUTH, 10, 1'b0},
        '{"long_north",   1, 15, NORTH, 10, 1'b0}
    };

    // Front wall inset per depth
    int dist_tab [0:10] = '{30, 55, 78, 94, 110, 124, 134, 143, 151, 158, 164};

    logic                    clk, rstn, refresh, cmd_done;
    col_t                    pose_col;
    row_t                    pose_row;
    dir_t                    pose_dir;
    logic                    cmd_start, busy, done;
    shape_t                  cmd_shape;
    logic [8:0]              cmd_color;
    logic signed [CORDW-1:0] cmd_x0, cmd_y0, cmd_x1, cmd_y1;
    logic signed [CORDW-1:0] cmd_x2, cmd_y2, cmd_x3, cmd_y3;

    cmd_t cmds [$];            // Commands seen this frame
    int   done_count;
    int   errors, proto_errors, checks;
    int   tests_run, tests_failed;
    logic timed_out;

    maze_top #(.CORDW(CORDW)) i_maze_top (
        .clk, .rstn, .refresh, .pose_col, .pose_row, .pose_dir, .cmd_done,
        .cmd_start, .cmd_shape, .cmd_color,
        .cmd_x0, .cmd_y0, .cmd_x1, .cmd_y1, .cmd_x2, .cmd_y2, .cmd_x3, .cmd_y3,
        .busy, .done
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // ==============================
    // Rasteriser model
    // ==============================
    initial begin : rasteriser
        int   wait_cyc;
        logic pending;
        void'($urandom(32'hd0d0f834));
        cmd_done <= 1'b0;
        pending  = 1'b0;
        wait_cyc = 0;
        forever begin
            @(negedge clk);
            if (cmd_start) begin
                if (pending) begin
                    proto_errors++;
                    $display("second command started while one was outstanding");
                end
                cmds.push_back(build_cmd(int'(cmd_shape), int'(cmd_color),
                                         int'(cmd_x0), int'(cmd_y0),
                                         int'(cmd_x1), int'(cmd_y1),
                                         int'(cmd_x2), int'(cmd_y2),
                                         int'(cmd_x3), int'(cmd_y3)));
                pending  = 1'b1;
                wait_cyc = $urandom_range(8, 1);
            end
            @(posedge clk);
            cmd_done <= 1'b0;
            if (pending) begin
                if (wait_cyc <= 1) begin
                    cmd_done <= 1'b1;
                    pending  = 1'b0;
                end else begin
                    wait_cyc--;
                end
            end
        end
    end

    always @(negedge clk) begin
        if (done) done_count++;
    end

    task automatic compare(input string what, input int exp, input int act);
        checks++;
        if (exp !== act) begin
            errors++;
            $display("ERR %s: expected %0d, actual %0d", what, exp, act);
        end
    endtask

    function automatic cmd_t build_cmd(input int shape, color, x0, y0, x1, y1,
                                       x2, y2, x3, y3);
        return '{shape, color, x0, y0, x1, y1, x2, y2, x3, y3};
    endfunction

    task automatic match_cmd(input string tag, input cmd_t want, input cmd_t got);
        compare({tag, " shape"}, want.shape, got.shape);
        compare({tag, " colour"}, want.color, got.color);
        compare({tag, " x0"}, want.x0, got.x0);
        compare({tag, " y0"}, want.y0, got.y0);
        compare({tag, " x1"}, want.x1, got.x1);
        compare({tag, " y1"}, want.y1, got.y1);
        compare({tag, " x2"}, want.x2, got.x2);
        compare({tag, " y2"}, want.y2, got.y2);
        compare({tag, " x3"}, want.x3, got.x3);
        compare({tag, " y3"}, want.y3, got.y3);
    endtask

    task automatic await_cmds(input string tname, input int n, input int limit);
        int cyc;
        cyc = 0;
        while (cmds.size() < n && cyc < limit) begin
            @(posedge clk);
            cyc++;
        end
        if (cmds.size() < n) begin
            timed_out = 1'b1;
            $display("%s: only %0d of %0d commands started within %0d cycles",
                     tname, cmds.size(), n, limit);
        end
    endtask

    task automatic wait_done(input string tname, input int limit);
        int cyc;
        cyc = 0;
        while (done_count == 0 && cyc < limit) begin
            @(posedge clk);
            cyc++;
        end
        if (done_count == 0) begin
            timed_out = 1'b1;
            $display("%s: no done pulse within %0d cycles", tname, limit);
        end
    endtask

    // ==============================
    // Expected frame contents
    // ==============================
    task automatic score_frame(input stim_t s, input string tname);
        cmd_t want;
        int   k, bx, by, d;
        compare({tname, " command count"}, NUM_CMDS, cmds.size());
        if (cmds.size() != NUM_CMDS) return;
        want = build_cmd(SHP_RECT, COL_FLOOR, 0, 0, 640, 480, 0, 0, 0, 0);
        match_cmd({tname, " clear"}, want, cmds[0]);
        for (int r = 0; r < MAP_ROWS; r++) begin
            for (int c = 0; c < MAP_COLS; c++) begin
                k  = 1 + r * MAP_COLS + c;   // Row-major after the clear
                bx = 420 + c * 20;
                by = 30 + r * 20;
                want = build_cmd(SHP_RECT, maze_map[r][c] ? COL_WALL : COL_FLOOR,
                                 bx, by, bx + 20, by + 20, 0, 0, 0, 0);
                match_cmd($sformatf("%s cell %0d,%0d", tname, c, r), want, cmds[k]);
            end
        end
        bx = 420 + s.col * 20;
        by = 30 + s.row * 20;
        case (s.dir)
            EAST: want = build_cmd(SHP_TRI, COL_WALL, bx, by, bx + 20, by + 10,
                                   bx, by + 20, 0, 0);
            NORTH: want = build_cmd(SHP_TRI, COL_WALL, bx + 10, by, bx + 20, by + 20,
                                    bx, by + 20, 0, 0);
            WEST: want = build_cmd(SHP_TRI, COL_WALL, bx + 20, by, bx + 20, by + 20,
                                   bx, by + 10, 0, 0);
            default: want = build_cmd(SHP_TRI, COL_WALL, bx, by, bx + 20, by,
                                      bx + 10, by + 20, 0, 0);
        endcase
        match_cmd({tname, " player"}, want, cmds[232]);
        want = build_cmd(SHP_QUAD, COL_LINE, 0, 0, 400, 0, 400, 400, 0, 400);
        match_cmd({tname, " frame"}, want, cmds[233]);
        d    = dist_tab[s.depth];
        want = build_cmd(SHP_QUAD, COL_LINE, d, d, 400 - d, d, 400 - d, 400 - d,
                         d, 400 - d);
        match_cmd({tname, " front"}, want, cmds[234]);
    endtask

    task automatic run_frame(input stim_t s);
        string tname;
        int    err0;
        tname      = string'(s.name);
        err0       = errors;
        cmds.delete();
        done_count = 0;
        @(posedge clk);
        pose_col <= col_t'(s.col);
        pose_row <= row_t'(s.row);
        pose_dir <= s.dir;
        refresh  <= 1'b1;
        @(posedge clk);
        refresh <= 1'b0;
        await_cmds(tname, 1, 200);
        if (!timed_out && s.poke) begin
            await_cmds(tname, 100, 2000);
            @(posedge clk);
            refresh <= 1'b1;     // Lands mid-frame, must be ignored
            @(posedge clk);
            refresh <= 1'b0;
        end
        if (!timed_out) wait_done(tname, 4000);
        if (!timed_out) begin
            repeat (3) @(negedge clk);
            compare({tname, " busy after done"}, 0, busy);
            compare({tname, " done pulses"}, 1, done_count);
            score_frame(s, tname);
        end
        tests_run++;
        if (timed_out || errors != err0) tests_failed++;
        $display("test %-12s %0d mismatches", tname, errors - err0);
    endtask

    // ==============================
    // Main sequence
    // ==============================
    initial begin
        int err0;
        rstn         <= 1'b0;
        refresh      <= 1'b0;
        pose_col     <= 4'd1;
        pose_row     <= 5'd7;
        pose_dir     <= SOUTH;
        errors       = 0;
        proto_errors = 0;
        checks       = 0;
        tests_run    = 0;
        tests_failed = 0;
        timed_out    = 1'b0;
        done_count   = 0;
        repeat (2) @(posedge clk);
        rstn <= 1'b1;

        // Idle after reset, no refresh
        err0 = errors;
        repeat (5) begin
            @(negedge clk);
            compare("reset_idle busy", 0, busy);
            compare("reset_idle done", 0, done);
            compare("reset_idle cmd_start", 0, cmd_start);
        end
        tests_run++;
        if (errors != err0) tests_failed++;
        $display("test %-12s %0d mismatches", "reset_idle", errors - err0);

        foreach (stim_table[t]) begin
            if (!timed_out) run_frame(stim_table[t]);
        end

        $display("tests %0d, failed %0d, checks %0d, mismatches %0d, protocol errors %0d",
                 tests_run, tests_failed, checks, errors, proto_errors);
        if (errors == 0 && proto_errors == 0 && !timed_out) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

// File: project.f
rtl/maze_pkg.sv
rtl/shape_req_if.sv
rtl/pose_regs.sv
rtl/depth_probe.sv
rtl/frame_sequencer.sv
rtl/shape_geometry.sv
rtl/maze_top.sv
tb/maze_checker.sv
tb/maze_tb.sv

// File: Makefile
# Verilator build and run of the maze view testbench
SRCS := $(wildcard rtl/*.sv tb/*.sv)

.PHONY: all run clean

all: run

obj_dir/maze_sim: $(SRCS) project.f
	verilator --binary --timing --assert -Wno-fatal --top-module maze_tb \
		-f project.f -o maze_sim --Mdir obj_dir

run: obj_dir/maze_sim
	./obj_dir/maze_sim > sim.log 2>&1 || true
	cat sim.log
	! grep -q "STATUS: FAIL" sim.log
	grep -q "STATUS: PASS" sim.log

clean:
	rm -rf obj_dir sim.log
